/* common/mips_isa_pkg.sv */
package mips_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [15:0] imm16_t;

    // low bit of each instruction field.
    localparam int OPC_LSB   = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_LSB = 6;

    // primary opcodes.
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0A;
    localparam logic [5:0] OP_ANDI    = 6'h0C;
    localparam logic [5:0] OP_ORI     = 6'h0D;
    localparam logic [5:0] OP_LUI     = 6'h0F;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2B;

    // function codes under OP_SPECIAL.
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2A;

endpackage

/* common/core_cfg_pkg.sv */
package core_cfg_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [4:0]  shamt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    // what the result stage does with an executed instruction.
    typedef enum logic [1:0] {
        RES_NONE,
        RES_REG,
        RES_LOAD,
        RES_STORE
    } res_kind_e;

    typedef enum logic [1:0] {
        F_IDLE,
        F_BUS,
        F_WAIT
    } fetch_state_e;

    typedef enum logic [1:0] {
        M_IDLE,
        M_BUS,
        M_DONE
    } mem_state_e;

endpackage

/* rtl/decode/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                   Clk,
    input  logic                   Myreset,
    input  core_cfg_pkg::reg_idx_t raddr_a_i,
    input  core_cfg_pkg::reg_idx_t raddr_b_i,
    input  logic                   we_i,
    input  core_cfg_pkg::reg_idx_t waddr_i,
    input  core_cfg_pkg::word_t    wdata_i,
    output core_cfg_pkg::word_t    rdata_a_o,
    output core_cfg_pkg::word_t    rdata_b_o
);

    core_cfg_pkg::word_t regs_q [32];

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // $zero reads as zero.
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* rtl/decode/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                    Clk,
    input  logic                    Myreset,
    input  logic                    instr_valid_i,
    input  mips_isa_pkg::instr_t    instr_i,
    input  core_cfg_pkg::addr_t     pc_i,
    input  logic                    rf_we_i,
    input  core_cfg_pkg::reg_idx_t  rf_waddr_i,
    input  core_cfg_pkg::word_t     rf_wdata_i,
    output logic                    dec_valid_o,
    output core_cfg_pkg::alu_op_e   alu_op_o,
    output core_cfg_pkg::res_kind_e res_kind_o,
    output core_cfg_pkg::word_t     opa_o,
    output core_cfg_pkg::word_t     opb_o,
    output core_cfg_pkg::word_t     store_data_o,
    output core_cfg_pkg::shamt_t    shamt_o,
    output core_cfg_pkg::reg_idx_t  dest_o,
    output logic                    is_beq_o,
    output logic                    is_bne_o,
    output logic                    is_jump_o,
    output core_cfg_pkg::word_t     imm_o,
    output logic                    use_imm_o,
    output core_cfg_pkg::addr_t     pc_o
);

    logic [5:0]                opcode, funct;
    core_cfg_pkg::reg_idx_t    rs, rt, rd, dest_d;
    mips_isa_pkg::imm16_t      imm16;
    core_cfg_pkg::word_t       rs_data, rt_data, imm_d;
    core_cfg_pkg::alu_op_e     alu_op_d;
    core_cfg_pkg::res_kind_e   res_kind_d;
    logic                      use_imm_d, is_beq_d, is_bne_d, is_jump_d;
    logic                      in_flight_q;

    assign opcode = instr_i[mips_isa_pkg::OPC_LSB +: 6];
    assign rs     = instr_i[mips_isa_pkg::RS_LSB +: 5];
    assign rt     = instr_i[mips_isa_pkg::RT_LSB +: 5];
    assign rd     = instr_i[mips_isa_pkg::RD_LSB +: 5];
    assign funct  = instr_i[5:0];
    assign imm16  = instr_i[15:0];

    reg_file u_reg_file (
        .Clk(Clk), .Myreset(Myreset), .raddr_a_i(rs), .raddr_b_i(rt), .we_i(rf_we_i),
        .waddr_i(rf_waddr_i), .wdata_i(rf_wdata_i), .rdata_a_o(rs_data), .rdata_b_o(rt_data)
    );

    always_comb begin
        alu_op_d   = core_cfg_pkg::ALU_ADD;
        res_kind_d = core_cfg_pkg::RES_NONE;
        dest_d     = rt;
        imm_d      = {{16{imm16[15]}}, imm16};
        use_imm_d  = 1'b1;
        is_beq_d   = 1'b0;
        is_bne_d   = 1'b0;
        is_jump_d  = 1'b0;
        case (opcode)
            mips_isa_pkg::OP_SPECIAL: begin
                dest_d     = rd;
                use_imm_d  = 1'b0;
                res_kind_d = core_cfg_pkg::RES_REG;
                case (funct)
                    mips_isa_pkg::FN_ADDU: alu_op_d = core_cfg_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUBU: alu_op_d = core_cfg_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND:  alu_op_d = core_cfg_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:   alu_op_d = core_cfg_pkg::ALU_OR;
                    mips_isa_pkg::FN_XOR:  alu_op_d = core_cfg_pkg::ALU_XOR;
                    mips_isa_pkg::FN_SLT:  alu_op_d = core_cfg_pkg::ALU_SLT;
                    mips_isa_pkg::FN_SLL:  alu_op_d = core_cfg_pkg::ALU_SLL;
                    mips_isa_pkg::FN_SRL:  alu_op_d = core_cfg_pkg::ALU_SRL;
                    default:               res_kind_d = core_cfg_pkg::RES_NONE;
                endcase
            end
            mips_isa_pkg::OP_ADDIU: res_kind_d = core_cfg_pkg::RES_REG;
            mips_isa_pkg::OP_SLTI: begin
                alu_op_d   = core_cfg_pkg::ALU_SLT;
                res_kind_d = core_cfg_pkg::RES_REG;
            end
            mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_LUI: begin
                imm_d      = {16'h0000, imm16};
                res_kind_d = core_cfg_pkg::RES_REG;
                if (opcode == mips_isa_pkg::OP_ANDI) begin
                    alu_op_d = core_cfg_pkg::ALU_AND;
                end else if (opcode == mips_isa_pkg::OP_ORI) begin
                    alu_op_d = core_cfg_pkg::ALU_OR;
                end else begin
                    alu_op_d = core_cfg_pkg::ALU_LUI;
                end
            end
            mips_isa_pkg::OP_LW: res_kind_d = core_cfg_pkg::RES_LOAD;
            mips_isa_pkg::OP_SW: res_kind_d = core_cfg_pkg::RES_STORE;
            mips_isa_pkg::OP_BEQ: begin
                is_beq_d  = 1'b1;
                use_imm_d = 1'b0;
            end
            mips_isa_pkg::OP_BNE: begin
                is_bne_d  = 1'b1;
                use_imm_d = 1'b0;
            end
            mips_isa_pkg::OP_J: begin
                is_jump_d = 1'b1;
                imm_d     = {6'b000000, instr_i[25:0]};
            end
            default: ;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            dec_valid_o <= 1'b0;
            in_flight_q <= 1'b0;
        end else begin
            dec_valid_o <= instr_valid_i;
            if (instr_valid_i) begin
                in_flight_q <= 1'b1;
            end else if (dec_valid_o) begin
                in_flight_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (instr_valid_i) begin
            alu_op_o     <= alu_op_d;
            res_kind_o   <= res_kind_d;
            opa_o        <= rs_data;
            opb_o        <= rt_data;
            store_data_o <= rt_data;
            shamt_o      <= instr_i[mips_isa_pkg::SHAMT_LSB +: 5];
            dest_o       <= dest_d;
            is_beq_o     <= is_beq_d;
            is_bne_o     <= is_bne_d;
            is_jump_o    <= is_jump_d;
            imm_o        <= imm_d;
            use_imm_o    <= use_imm_d;
            pc_o         <= pc_i;
        end
    end

    a_single_issue: assert property (@(posedge Clk) disable iff (Myreset)
        in_flight_q |-> !instr_valid_i);

endmodule

/* rtl/execute/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                    Clk,
    input  logic                    Myreset,
    input  logic                    dec_valid_i,
    input  core_cfg_pkg::alu_op_e   alu_op_i,
    input  core_cfg_pkg::res_kind_e res_kind_i,
    input  core_cfg_pkg::word_t     opa_i,
    input  core_cfg_pkg::word_t     opb_i,
    input  core_cfg_pkg::word_t     store_data_i,
    input  core_cfg_pkg::shamt_t    shamt_i,
    input  core_cfg_pkg::reg_idx_t  dest_i,
    input  logic                    is_beq_i,
    input  logic                    is_bne_i,
    input  logic                    is_jump_i,
    input  core_cfg_pkg::word_t     imm_i,
    input  logic                    use_imm_i,
    input  core_cfg_pkg::addr_t     pc_i,
    output logic                    ex_valid_o,
    output core_cfg_pkg::word_t     result_o,
    output core_cfg_pkg::word_t     store_data_o,
    output core_cfg_pkg::reg_idx_t  dest_o,
    output core_cfg_pkg::res_kind_e res_kind_o,
    output core_cfg_pkg::addr_t     next_pc_o,
    output core_cfg_pkg::addr_t     pc_o
);

    core_cfg_pkg::word_t alu_b, alu_res;
    core_cfg_pkg::addr_t pc_plus4, next_pc;
    logic                taken;

    assign alu_b = use_imm_i ? imm_i : opb_i;

    // lw and sw come here as ALU_ADD, so the result is the byte address.
    always_comb begin
        case (alu_op_i)
            core_cfg_pkg::ALU_ADD: alu_res = opa_i + alu_b;
            core_cfg_pkg::ALU_SUB: alu_res = opa_i - alu_b;
            core_cfg_pkg::ALU_AND: alu_res = opa_i & alu_b;
            core_cfg_pkg::ALU_OR:  alu_res = opa_i | alu_b;
            core_cfg_pkg::ALU_XOR: alu_res = opa_i ^ alu_b;
            core_cfg_pkg::ALU_SLT: alu_res = {31'b0, $signed(opa_i) < $signed(alu_b)};
            core_cfg_pkg::ALU_SLL: alu_res = alu_b << shamt_i;
            core_cfg_pkg::ALU_SRL: alu_res = alu_b >> shamt_i;
            core_cfg_pkg::ALU_LUI: alu_res = {alu_b[15:0], 16'h0000};
            default:               alu_res = '0;
        endcase
    end

    assign pc_plus4 = pc_i + 32'd4;
    assign taken    = (is_beq_i && opa_i == opb_i) || (is_bne_i && opa_i != opb_i);

    always_comb begin
        if (is_jump_i) begin
            next_pc = {pc_plus4[31:28], imm_i[25:0], 2'b00};
        end else if (taken) begin
            next_pc = pc_plus4 + {imm_i[29:0], 2'b00};
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge Clk) begin
        if (dec_valid_i) begin
            result_o     <= alu_res;
            store_data_o <= store_data_i;
            dest_o       <= dest_i;
            res_kind_o   <= res_kind_i;
            next_pc_o    <= next_pc;
            pc_o         <= pc_i;
        end
    end

endmodule

/* rtl/result/result_stage.sv */
`timescale 1ns/1ps

module result_stage (
    input  logic                    Clk,
    input  logic                    Myreset,
    input  logic                    ex_valid_i,
    input  core_cfg_pkg::word_t     result_i,
    input  core_cfg_pkg::word_t     store_data_i,
    input  core_cfg_pkg::reg_idx_t  dest_i,
    input  core_cfg_pkg::res_kind_e res_kind_i,
    input  core_cfg_pkg::addr_t     next_pc_i,
    input  core_cfg_pkg::addr_t     pc_i,
    input  core_cfg_pkg::word_t     dwb_dat_i,
    input  logic                    dwb_ack_i,
    output logic                    dwb_cyc_o,
    output logic                    dwb_stb_o,
    output logic                    dwb_we_o,
    output core_cfg_pkg::addr_t     dwb_adr_o,
    output core_cfg_pkg::word_t     dwb_dat_o,
    output logic                    rf_we_o,
    output core_cfg_pkg::reg_idx_t  rf_waddr_o,
    output core_cfg_pkg::word_t     rf_wdata_o,
    output logic                    retire_o,
    output core_cfg_pkg::addr_t     next_pc_o,
    output core_cfg_pkg::addr_t     debug_wb_pc_o,
    output logic [3:0]              debug_wb_rf_wen_o,
    output core_cfg_pkg::reg_idx_t  debug_wb_rf_wnum_o,
    output core_cfg_pkg::word_t     debug_wb_rf_wdata_o
);

    core_cfg_pkg::mem_state_e state_q;
    core_cfg_pkg::res_kind_e  kind_q;
    core_cfg_pkg::reg_idx_t   dest_q, trc_num_q;
    core_cfg_pkg::word_t      res_q, store_q, trc_data_q;
    core_cfg_pkg::addr_t      pc_q, npc_q, trc_pc_q;
    logic                     is_mem;

    assign is_mem = (res_kind_i == core_cfg_pkg::RES_LOAD) ||
                    (res_kind_i == core_cfg_pkg::RES_STORE);

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            state_q <= core_cfg_pkg::M_IDLE;
        end else begin
            case (state_q)
                core_cfg_pkg::M_IDLE: begin
                    if (ex_valid_i) begin
                        state_q <= is_mem ? core_cfg_pkg::M_BUS : core_cfg_pkg::M_DONE;
                    end
                end
                core_cfg_pkg::M_BUS: begin
                    if (dwb_ack_i) begin
                        state_q <= core_cfg_pkg::M_DONE;
                    end
                end
                default: begin
                    state_q <= core_cfg_pkg::M_IDLE;
                end
            endcase
        end
    end

    // res_q holds the address during the bus cycle, then the loaded word.
    always_ff @(posedge Clk) begin
        if (ex_valid_i) begin
            kind_q  <= res_kind_i;
            dest_q  <= dest_i;
            res_q   <= result_i;
            store_q <= store_data_i;
            pc_q    <= pc_i;
            npc_q   <= next_pc_i;
        end else if (dwb_stb_o && dwb_ack_i && kind_q == core_cfg_pkg::RES_LOAD) begin
            res_q <= dwb_dat_i;
        end
    end

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            trc_pc_q   <= '0;
            trc_num_q  <= '0;
            trc_data_q <= '0;
        end else if (retire_o) begin
            trc_pc_q   <= pc_q;
            trc_num_q  <= dest_q;
            trc_data_q <= res_q;
        end
    end

    assign retire_o   = (state_q == core_cfg_pkg::M_DONE);
    assign next_pc_o  = npc_q;
    assign rf_we_o    = retire_o && dest_q != '0 &&
                        (kind_q == core_cfg_pkg::RES_REG || kind_q == core_cfg_pkg::RES_LOAD);
    assign rf_waddr_o = dest_q;
    assign rf_wdata_o = res_q;

    assign dwb_cyc_o = (state_q == core_cfg_pkg::M_BUS);
    assign dwb_stb_o = dwb_cyc_o;
    assign dwb_we_o  = dwb_cyc_o && kind_q == core_cfg_pkg::RES_STORE;
    assign dwb_adr_o = res_q;
    assign dwb_dat_o = store_q;

    // live values in the retire cycle, held copy afterwards.
    assign debug_wb_pc_o       = retire_o ? pc_q : trc_pc_q;
    assign debug_wb_rf_wnum_o  = retire_o ? dest_q : trc_num_q;
    assign debug_wb_rf_wdata_o = retire_o ? res_q : trc_data_q;
    assign debug_wb_rf_wen_o   = {4{rf_we_o}};

    a_word_aligned: assert property (@(posedge Clk) disable iff (Myreset)
        dwb_stb_o |-> dwb_adr_o[1:0] == 2'b00);

endmodule

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
    parameter core_cfg_pkg::addr_t RESET_PC = 32'hBFC0_0000
) (
    input  logic                 Clk,
    input  logic                 Myreset,
    input  logic                 retire_i,
    input  core_cfg_pkg::addr_t  next_pc_i,
    input  core_cfg_pkg::word_t  iwb_dat_i,
    input  logic                 iwb_ack_i,
    output logic                 iwb_cyc_o,
    output logic                 iwb_stb_o,
    output core_cfg_pkg::addr_t  iwb_adr_o,
    output logic                 instr_valid_o,
    output mips_isa_pkg::instr_t instr_o,
    output core_cfg_pkg::addr_t  pc_o
);

    core_cfg_pkg::fetch_state_e state_q;
    core_cfg_pkg::addr_t        pc_q;
    logic                       fetch_done;

    assign fetch_done = (state_q == core_cfg_pkg::F_BUS) && iwb_ack_i;

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            state_q       <= core_cfg_pkg::F_IDLE;
            pc_q          <= RESET_PC;
            instr_valid_o <= 1'b0;
        end else begin
            instr_valid_o <= fetch_done;
            case (state_q)
                core_cfg_pkg::F_IDLE: begin
                    state_q <= core_cfg_pkg::F_BUS;
                end
                core_cfg_pkg::F_BUS: begin
                    if (iwb_ack_i) begin
                        state_q <= core_cfg_pkg::F_WAIT;
                    end
                end
                core_cfg_pkg::F_WAIT: begin
                    // one instruction in flight, next fetch only after it retires.
                    if (retire_i) begin
                        pc_q    <= next_pc_i;
                        state_q <= core_cfg_pkg::F_BUS;
                    end
                end
                default: begin
                    state_q <= core_cfg_pkg::F_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (fetch_done) begin
            instr_o <= iwb_dat_i;
        end
    end

    assign iwb_cyc_o = (state_q == core_cfg_pkg::F_BUS);
    assign iwb_stb_o = iwb_cyc_o;
    assign iwb_adr_o = pc_q;
    assign pc_o      = pc_q;

    a_stb_cyc: assert property (@(posedge Clk) disable iff (Myreset)
        iwb_stb_o |-> iwb_cyc_o);

    a_adr_hold: assert property (@(posedge Clk) disable iff (Myreset)
        iwb_stb_o && !iwb_ack_i |=> $stable(iwb_adr_o));

endmodule

/* rtl/core_top.sv */
`timescale 1ns/1ps

module core_top #(
    parameter core_cfg_pkg::addr_t RESET_PC = 32'hBFC0_0000
) (
    input  logic                   Clk,
    input  logic                   Myreset,
    input  core_cfg_pkg::word_t    iwb_dat_i,
    input  logic                   iwb_ack_i,
    output logic                   iwb_cyc_o,
    output logic                   iwb_stb_o,
    output core_cfg_pkg::addr_t    iwb_adr_o,
    input  core_cfg_pkg::word_t    dwb_dat_i,
    input  logic                   dwb_ack_i,
    output logic                   dwb_cyc_o,
    output logic                   dwb_stb_o,
    output logic                   dwb_we_o,
    output core_cfg_pkg::addr_t    dwb_adr_o,
    output core_cfg_pkg::word_t    dwb_dat_o,
    output core_cfg_pkg::addr_t    debug_wb_pc_o,
    output logic [3:0]             debug_wb_rf_wen_o,
    output core_cfg_pkg::reg_idx_t debug_wb_rf_wnum_o,
    output core_cfg_pkg::word_t    debug_wb_rf_wdata_o
);

    logic                    instr_valid, dec_valid, ex_valid, retire, rf_we;
    logic                    is_beq, is_bne, is_jump, use_imm;
    mips_isa_pkg::instr_t    instr;
    core_cfg_pkg::addr_t     f_pc, d_pc, ex_pc, ex_next_pc, next_pc;
    core_cfg_pkg::alu_op_e   alu_op;
    core_cfg_pkg::res_kind_e d_res_kind, ex_res_kind;
    core_cfg_pkg::word_t     opa, opb, imm, d_store_data, ex_store_data, ex_result, rf_wdata;
    core_cfg_pkg::shamt_t    shamt;
    core_cfg_pkg::reg_idx_t  d_dest, ex_dest, rf_waddr;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .Clk(Clk), .Myreset(Myreset), .retire_i(retire), .next_pc_i(next_pc),
        .iwb_dat_i(iwb_dat_i), .iwb_ack_i(iwb_ack_i), .iwb_cyc_o(iwb_cyc_o),
        .iwb_stb_o(iwb_stb_o), .iwb_adr_o(iwb_adr_o),
        .instr_valid_o(instr_valid), .instr_o(instr), .pc_o(f_pc)
    );

    decode_stage u_decode (
        .Clk(Clk), .Myreset(Myreset), .instr_valid_i(instr_valid), .instr_i(instr),
        .pc_i(f_pc), .rf_we_i(rf_we), .rf_waddr_i(rf_waddr), .rf_wdata_i(rf_wdata),
        .dec_valid_o(dec_valid), .alu_op_o(alu_op), .res_kind_o(d_res_kind),
        .opa_o(opa), .opb_o(opb), .store_data_o(d_store_data), .shamt_o(shamt),
        .dest_o(d_dest), .is_beq_o(is_beq), .is_bne_o(is_bne), .is_jump_o(is_jump),
        .imm_o(imm), .use_imm_o(use_imm), .pc_o(d_pc)
    );

    execute_stage u_execute (
        .Clk(Clk), .Myreset(Myreset), .dec_valid_i(dec_valid), .alu_op_i(alu_op),
        .res_kind_i(d_res_kind), .opa_i(opa), .opb_i(opb), .store_data_i(d_store_data),
        .shamt_i(shamt), .dest_i(d_dest), .is_beq_i(is_beq), .is_bne_i(is_bne),
        .is_jump_i(is_jump), .imm_i(imm), .use_imm_i(use_imm), .pc_i(d_pc),
        .ex_valid_o(ex_valid), .result_o(ex_result), .store_data_o(ex_store_data),
        .dest_o(ex_dest), .res_kind_o(ex_res_kind), .next_pc_o(ex_next_pc), .pc_o(ex_pc)
    );

    result_stage u_result (
        .Clk(Clk), .Myreset(Myreset), .ex_valid_i(ex_valid), .result_i(ex_result),
        .store_data_i(ex_store_data), .dest_i(ex_dest), .res_kind_i(ex_res_kind),
        .next_pc_i(ex_next_pc), .pc_i(ex_pc), .dwb_dat_i(dwb_dat_i), .dwb_ack_i(dwb_ack_i),
        .dwb_cyc_o(dwb_cyc_o), .dwb_stb_o(dwb_stb_o), .dwb_we_o(dwb_we_o),
        .dwb_adr_o(dwb_adr_o), .dwb_dat_o(dwb_dat_o), .rf_we_o(rf_we),
        .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata), .retire_o(retire),
        .next_pc_o(next_pc), .debug_wb_pc_o(debug_wb_pc_o),
        .debug_wb_rf_wen_o(debug_wb_rf_wen_o), .debug_wb_rf_wnum_o(debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

endmodule

/* test/tb_wb_memory.sv */
`timescale 1ns/1ps

module tb_wb_memory #(
    parameter int AW        = 8,
    parameter bit READ_ONLY = 1'b0
) (
    input  logic        Clk,
    input  logic        Myreset,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [31:0] adr_i,
    input  logic [31:0] dat_i,
    input  logic [1:0]  wait_i,
    output logic [31:0] dat_o,
    output logic        ack_o
);

    logic [31:0]   mem [2**AW];
    logic [1:0]    cnt_q;
    logic [AW-1:0] idx;

    // word addressed, upper address bits wrap.
    assign idx = adr_i[AW+1:2];

    initial begin
        ack_o = 1'b0;
        dat_o = '0;
        cnt_q = '0;
    end

    always @(posedge Clk) begin
        if (Myreset) begin
            ack_o <= 1'b0;
            cnt_q <= '0;
        end else if (cyc_i && stb_i && !ack_o) begin
            // wait_i cycles of delay before ack.
            if (cnt_q == wait_i) begin
                ack_o <= 1'b1;
                cnt_q <= '0;
                dat_o <= mem[idx];
                if (we_i && !READ_ONLY) begin
                    mem[idx] <= dat_i;
                end
            end else begin
                cnt_q <= cnt_q + 2'd1;
            end
        end else begin
            ack_o <= 1'b0;
            cnt_q <= '0;
        end
    end

endmodule

/* test/tb_core_top.sv */
`timescale 1ns/1ps

module tb_core_top;

    localparam int MEM_AW   = 8;
    localparam int MAX_WAIT = 3;

    logic                   Clk, Myreset;
    logic                   iwb_cyc, iwb_stb, iwb_ack, dwb_cyc, dwb_stb, dwb_we, dwb_ack;
    core_cfg_pkg::addr_t    iwb_adr, dwb_adr, trace_pc;
    core_cfg_pkg::word_t    iwb_rdata, dwb_rdata, dwb_wdata, trace_data;
    logic [3:0]             trace_wen;
    core_cfg_pkg::reg_idx_t trace_num;
    logic [1:0]             iwb_wait, dwb_wait;
    logic [15:0]            lfsr_q;
    int                     cycles, row, cycle_limit;

    mips_isa_pkg::instr_t   prog_q [$];
    core_cfg_pkg::addr_t    exp_pc_q [$];
    core_cfg_pkg::reg_idx_t exp_num_q [$];
    core_cfg_pkg::word_t    exp_data_q [$];

    core_top #(
        .RESET_PC(32'h0000_0000)
    ) u_dut (
        .Clk(Clk), .Myreset(Myreset), .iwb_dat_i(iwb_rdata), .iwb_ack_i(iwb_ack),
        .iwb_cyc_o(iwb_cyc), .iwb_stb_o(iwb_stb), .iwb_adr_o(iwb_adr),
        .dwb_dat_i(dwb_rdata), .dwb_ack_i(dwb_ack), .dwb_cyc_o(dwb_cyc), .dwb_stb_o(dwb_stb),
        .dwb_we_o(dwb_we), .dwb_adr_o(dwb_adr), .dwb_dat_o(dwb_wdata),
        .debug_wb_pc_o(trace_pc), .debug_wb_rf_wen_o(trace_wen),
        .debug_wb_rf_wnum_o(trace_num), .debug_wb_rf_wdata_o(trace_data)
    );

    tb_wb_memory #(.AW(MEM_AW), .READ_ONLY(1'b1)) u_imem (
        .Clk(Clk), .Myreset(Myreset), .cyc_i(iwb_cyc), .stb_i(iwb_stb), .we_i(1'b0),
        .adr_i(iwb_adr), .dat_i(32'h0), .wait_i(iwb_wait), .dat_o(iwb_rdata), .ack_o(iwb_ack)
    );

    tb_wb_memory #(.AW(MEM_AW), .READ_ONLY(1'b0)) u_dmem (
        .Clk(Clk), .Myreset(Myreset), .cyc_i(dwb_cyc), .stb_i(dwb_stb), .we_i(dwb_we),
        .adr_i(dwb_adr), .dat_i(dwb_wdata), .wait_i(dwb_wait), .dat_o(dwb_rdata), .ack_o(dwb_ack)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_wait(output logic [1:0] w);
        for (int i = 0; i < 2; i++) begin
            w[i]   = lfsr_q[0];
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    // preload pattern whose top byte decodes as an unsupported opcode.
    function automatic core_cfg_pkg::word_t fill_word(input int idx);
        return {8'hDA, idx[7:0], ~idx[7:0], 8'h5A};
    endfunction

    task automatic rr_instr(input logic [4:0] rs, rt, rd, sa, input logic [5:0] fn);
        prog_q.push_back({mips_isa_pkg::OP_SPECIAL, rs, rt, rd, sa, fn});
    endtask

    task automatic imm_instr(input logic [5:0] op, input logic [4:0] rs, rt,
                             input logic [15:0] imm);
        prog_q.push_back({op, rs, rt, imm});
    endtask

    task automatic jump_instr(input logic [25:0] idx);
        prog_q.push_back({mips_isa_pkg::OP_J, idx});
    endtask

    task automatic expect_write(input core_cfg_pkg::addr_t pc,
                                input core_cfg_pkg::reg_idx_t num,
                                input core_cfg_pkg::word_t data);
        exp_pc_q.push_back(pc);
        exp_num_q.push_back(num);
        exp_data_q.push_back(data);
    endtask

    task automatic build_tables();
        // r1 = 0x1234 and r2 = -16 feed the register ops.
        imm_instr(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h1234);
        expect_write(32'h00, 5'd1, 32'h0000_1234);
        imm_instr(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd2, 16'hFFF0);
        expect_write(32'h04, 5'd2, 32'hFFFF_FFF0);
        rr_instr(5'd1, 5'd2, 5'd3, 5'd0, mips_isa_pkg::FN_ADDU);
        expect_write(32'h08, 5'd3, 32'h0000_1224);
        rr_instr(5'd1, 5'd2, 5'd4, 5'd0, mips_isa_pkg::FN_SUBU);
        expect_write(32'h0C, 5'd4, 32'h0000_1244);
        rr_instr(5'd1, 5'd2, 5'd5, 5'd0, mips_isa_pkg::FN_AND);
        expect_write(32'h10, 5'd5, 32'h0000_1230);
        rr_instr(5'd1, 5'd2, 5'd6, 5'd0, mips_isa_pkg::FN_OR);
        expect_write(32'h14, 5'd6, 32'hFFFF_FFF4);
        rr_instr(5'd1, 5'd2, 5'd7, 5'd0, mips_isa_pkg::FN_XOR);
        expect_write(32'h18, 5'd7, 32'hFFFF_EDC4);
        rr_instr(5'd2, 5'd1, 5'd8, 5'd0, mips_isa_pkg::FN_SLT);
        expect_write(32'h1C, 5'd8, 32'h0000_0001);
        rr_instr(5'd1, 5'd2, 5'd9, 5'd0, mips_isa_pkg::FN_SLT);
        expect_write(32'h20, 5'd9, 32'h0000_0000);
        rr_instr(5'd0, 5'd1, 5'd10, 5'd4, mips_isa_pkg::FN_SLL);
        expect_write(32'h24, 5'd10, 32'h0001_2340);
        rr_instr(5'd0, 5'd2, 5'd11, 5'd8, mips_isa_pkg::FN_SRL);
        expect_write(32'h28, 5'd11, 32'h00FF_FFFF);
        // -16 < -32 is false, a zero-extended 0xFFE0 would give true.
        imm_instr(mips_isa_pkg::OP_SLTI, 5'd2, 5'd12, 16'hFFE0);
        expect_write(32'h2C, 5'd12, 32'h0000_0000);
        imm_instr(mips_isa_pkg::OP_ANDI, 5'd2, 5'd13, 16'hFF0F);
        expect_write(32'h30, 5'd13, 32'h0000_FF00);
        imm_instr(mips_isa_pkg::OP_ORI, 5'd0, 5'd14, 16'h8001);
        expect_write(32'h34, 5'd14, 32'h0000_8001);
        imm_instr(mips_isa_pkg::OP_LUI, 5'd0, 5'd15, 16'hDEAD);
        expect_write(32'h38, 5'd15, 32'hDEAD_0000);
        // store then load back, then a load of untouched memory.
        imm_instr(mips_isa_pkg::OP_SW, 5'd0, 5'd15, 16'h0040);
        imm_instr(mips_isa_pkg::OP_LW, 5'd0, 5'd16, 16'h0040);
        expect_write(32'h40, 5'd16, 32'hDEAD_0000);
        imm_instr(mips_isa_pkg::OP_LW, 5'd0, 5'd17, 16'h0080);
        expect_write(32'h44, 5'd17, fill_word(32'h80 >> 2));
        // write to $zero is dropped.
        rr_instr(5'd1, 5'd1, 5'd0, 5'd0, mips_isa_pkg::FN_ADDU);
        rr_instr(5'd0, 5'd1, 5'd18, 5'd0, mips_isa_pkg::FN_OR);
        expect_write(32'h4C, 5'd18, 32'h0000_1234);
        // branches and jump.
        imm_instr(mips_isa_pkg::OP_BEQ, 5'd1, 5'd2, 16'h0001);
        imm_instr(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd19, 16'h0007);
        expect_write(32'h54, 5'd19, 32'h0000_0007);
        imm_instr(mips_isa_pkg::OP_BEQ, 5'd1, 5'd18, 16'h0002);
        imm_instr(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd20, 16'h0001);
        imm_instr(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd20, 16'h0002);
        imm_instr(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd21, 16'h0003);
        expect_write(32'h64, 5'd21, 32'h0000_0003);
        imm_instr(mips_isa_pkg::OP_BNE, 5'd1, 5'd2, 16'h0001);
        imm_instr(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd22, 16'h0005);
        imm_instr(mips_isa_pkg::OP_BNE, 5'd1, 5'd18, 16'h0001);
        imm_instr(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd22, 16'h0006);
        expect_write(32'h74, 5'd22, 32'h0000_0006);
        jump_instr(26'h20);
        imm_instr(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd23, 16'h0008);
        imm_instr(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd23, 16'h0009);
        expect_write(32'h80, 5'd23, 32'h0000_0009);
        // park on a jump to itself.
        jump_instr(26'h21);
    endtask

    always #2 Clk = ~Clk;

    initial begin
        Clk     = 1'b0;
        Myreset = 1'b1;
        row     = 0;
        cycles  = 0;
        lfsr_q  = 16'd52763;
        build_tables();
        draw_wait(iwb_wait);
        draw_wait(dwb_wait);
        cycle_limit = prog_q.size() * (2 * MAX_WAIT + 8) * 2;
        for (int i = 0; i < 2**MEM_AW; i++) begin
            u_imem.mem[i] = (i < prog_q.size()) ? prog_q[i] : fill_word(i);
            u_dmem.mem[i] = fill_word(i);
        end
        repeat (5) @(posedge Clk);
        #1 Myreset = 1'b0;
        wait (row == exp_pc_q.size());
        $display("Simulation passed");
        $finish;
    end

    // new wait count for a port once its access has completed.
    always @(posedge Clk) begin
        logic i_done;
        logic d_done;
        i_done = iwb_stb && iwb_ack;
        d_done = dwb_stb && dwb_ack;
        #1;
        if (i_done) begin
            draw_wait(iwb_wait);
        end
        if (d_done) begin
            draw_wait(dwb_wait);
        end
    end

    always @(posedge Clk) begin
        cycles <= cycles + 1;
        assert (cycles < cycle_limit) else begin
            $display("timeout after %0d cycles, trace stopped at row %0d", cycles, row);
            $display("Simulation failed");
            $fatal(1, "run did not complete");
        end
    end

    always @(negedge Clk) begin
        if (!Myreset && trace_wen != 4'h0 && row < exp_pc_q.size()) begin
            assert (trace_wen == 4'hF && trace_pc == exp_pc_q[row] &&
                    trace_num == exp_num_q[row] && trace_data == exp_data_q[row]) else begin
                $display("FAILED at %0t: row %0d got pc %h r%0d=%h wen %h", $time, row,
                         trace_pc, trace_num, trace_data, trace_wen);
                $display("    expected pc %h r%0d=%h", exp_pc_q[row], exp_num_q[row],
                         exp_data_q[row]);
                $display("Simulation failed");
                $fatal(1, "trace mismatch");
            end
            row = row + 1;
        end
    end

endmodule

/* files.f */
common/mips_isa_pkg.sv
common/core_cfg_pkg.sv
rtl/decode/reg_file.sv
rtl/decode/decode_stage.sv
rtl/execute/execute_stage.sv
rtl/result/result_stage.sv
rtl/fetch_unit.sv
rtl/core_top.sv
test/tb_wb_memory.sv
test/tb_core_top.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - common/mips_isa_pkg.sv
  - common/core_cfg_pkg.sv
  - rtl/decode/reg_file.sv
  - rtl/decode/decode_stage.sv
  - rtl/execute/execute_stage.sv
  - rtl/result/result_stage.sv
  - rtl/fetch_unit.sv
  - rtl/core_top.sv
  - target: test
    files:
      - test/tb_wb_memory.sv
      - test/tb_core_top.sv
